// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_cp0_tlb
FILELIST  = src.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: cp0_exc_prio.sv
`timescale 1ns/10ps

module cp0_exc_prio (
	input  cp0_pkg::exc_vec_t  exc,
	output cp0_pkg::exc_info_t info
);

	always_comb begin
		info = '0;
		info.any = |exc;
		if (exc.intr) begin
			info.code = cp0_pkg::INT;
		end else if (exc.adel_if) begin
			info.code = cp0_pkg::ADEL;
			info.badv_wen = 1'b1;
		end else if (exc.refill_if || exc.inval_if) begin
			info.code = cp0_pkg::TLBL;
			info.tlb = 1'b1;
			info.refill = exc.refill_if;
			info.badv_wen = 1'b1;
		end else if (exc.ri) begin
			info.code = cp0_pkg::RI;
		end else if (exc.sys) begin
			info.code = cp0_pkg::SYS;
		end else if (exc.bp) begin
			info.code = cp0_pkg::BP;
		end else if (exc.ov) begin
			info.code = cp0_pkg::OV;
		end else if (exc.adel_ld) begin
			info.code = cp0_pkg::ADEL;
			info.badv_wen = 1'b1;
		end else if (exc.ades) begin
			info.code = cp0_pkg::ADES;
			info.badv_wen = 1'b1;
		end else if (exc.refill_ld || exc.inval_ld) begin
			info.code = cp0_pkg::TLBL;
			info.tlb = 1'b1;
			info.refill = exc.refill_ld;
			info.badv_wen = 1'b1;
		end else if (exc.refill_st || exc.inval_st) begin
			info.code = cp0_pkg::TLBS;
			info.tlb = 1'b1;
			info.refill = exc.refill_st;
			info.badv_wen = 1'b1;
		end else if (exc.mod) begin
			info.code = cp0_pkg::MOD;
			info.tlb = 1'b1;
			info.badv_wen = 1'b1;
		end
	end

endmodule

// File: cp0_pkg.sv
package cp0_pkg;

	// CP0 register numbers, select 0
	typedef enum logic [4:0] {
		INDEX    = 5'd0,
		ENTRYLO0 = 5'd2,
		ENTRYLO1 = 5'd3,
		BADVADDR = 5'd8,
		COUNT    = 5'd9,
		ENTRYHI  = 5'd10,
		COMPARE  = 5'd11,
		STATUS   = 5'd12,
		CAUSE    = 5'd13,
		EPC      = 5'd14
	} cp0_reg_e;

	typedef enum logic [4:0] {
		INT  = 5'd0,
		MOD  = 5'd1,
		TLBL = 5'd2,
		TLBS = 5'd3,
		ADEL = 5'd4,
		ADES = 5'd5,
		SYS  = 5'd8,
		BP   = 5'd9,
		RI   = 5'd10,
		OV   = 5'd12
	} exccode_e;

	typedef enum logic [1:0] {
		TLB_NONE,
		TLB_P,
		TLB_R,
		TLB_WI
	} tlb_op_e;

	// raw exception flags from the pipeline, refill_if is the msb
	typedef struct packed {
		logic refill_if;
		logic inval_if;
		logic refill_ld;
		logic inval_ld;
		logic refill_st;
		logic inval_st;
		logic mod;
		logic intr;
		logic adel_if;
		logic adel_ld;
		logic ades;
		logic sys;
		logic bp;
		logic ri;
		logic ov;
	} exc_vec_t;

	typedef struct packed {
		logic     any;
		exccode_e code;
		logic     tlb;
		logic     refill;
		logic     badv_wen;
	} exc_info_t;

	// even page (lo0) sits above the odd page (lo1)
	typedef struct packed {
		logic [18:0] vpn2;
		logic [7:0]  asid;
		logic        g;
		logic [19:0] pfn0;
		logic [2:0]  c0;
		logic        d0;
		logic        v0;
		logic [19:0] pfn1;
		logic [2:0]  c1;
		logic        d1;
		logic        v1;
	} tlb_entry_t;

	// same layout as the Index register, only the low index bits are nonzero
	typedef struct packed {
		logic        miss;
		logic [30:0] index;
	} probe_res_t;

endpackage

// File: cp0_regs.sv
`timescale 1ns/10ps

module cp0_regs #(
	parameter int TLBNUM = 16
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [7:0]                 addr,
	input  logic                       wen,
	input  logic [31:0]                wdata,
	output logic [31:0]                rdata,
	input  cp0_pkg::exc_info_t         info,
	input  logic [31:0]                pc,
	input  logic                       is_slot,
	input  logic [31:0]                bad_vaddr,
	input  logic [5:0]                 int_num,
	input  logic                       eret,
	output logic [31:0]                epc,
	output logic                       int_happen,
	output logic                       count_wen,
	output logic                       compare_wen,
	input  logic [31:0]                count,
	input  logic [31:0]                compare,
	input  logic                       ti,
	input  logic                       tlbp_wen,
	input  logic                       tlbr_wen,
	input  cp0_pkg::probe_res_t        probe,
	input  cp0_pkg::tlb_entry_t        rd_entry,
	output logic [31:0]                entryhi,
	output logic [$clog2(TLBNUM)-1:0]  tlb_index,
	output cp0_pkg::tlb_entry_t        wi_entry
);

	localparam int IW = $clog2(TLBNUM);

	logic [4:0]  reg_num;
	logic        sel0;
	logic        wr_status, wr_cause, wr_epc, wr_index;
	logic        wr_entryhi, wr_entrylo0, wr_entrylo1;
	logic [7:0]  im;
	logic        exl, ie, bd;
	logic [7:0]  ip;
	cp0_pkg::exccode_e exccode;
	logic [31:0] badvaddr;
	logic        index_p;
	logic [IW-1:0] index_v;
	logic [18:0] ehi_vpn2;
	logic [7:0]  ehi_asid;
	logic [25:0] lo0, lo1;
	logic [31:0] status, cause, index;

	assign reg_num = addr[7:3];
	assign sel0 = addr[2:0] == 3'd0;
	assign wr_status   = wen && sel0 && reg_num == cp0_pkg::STATUS;
	assign wr_cause    = wen && sel0 && reg_num == cp0_pkg::CAUSE;
	assign wr_epc      = wen && sel0 && reg_num == cp0_pkg::EPC;
	assign wr_index    = wen && sel0 && reg_num == cp0_pkg::INDEX;
	assign wr_entryhi  = wen && sel0 && reg_num == cp0_pkg::ENTRYHI;
	assign wr_entrylo0 = wen && sel0 && reg_num == cp0_pkg::ENTRYLO0;
	assign wr_entrylo1 = wen && sel0 && reg_num == cp0_pkg::ENTRYLO1;
	assign count_wen   = wen && sel0 && reg_num == cp0_pkg::COUNT;
	assign compare_wen = wen && sel0 && reg_num == cp0_pkg::COMPARE;

	// BEV hardwired to 1
	assign status  = {9'h0, 1'b1, 6'h0, im, 6'h0, exl, ie};
	assign cause   = {bd, ti, 14'h0, ip, 1'b0, exccode, 2'b0};
	assign index   = {index_p, {(31 - IW){1'b0}}, index_v};
	assign entryhi = {ehi_vpn2, 5'h0, ehi_asid};

	always_comb begin
		rdata = '0;
		if (sel0) begin
			case (reg_num)
				cp0_pkg::INDEX:    rdata = index;
				cp0_pkg::ENTRYLO0: rdata = {6'h0, lo0};
				cp0_pkg::ENTRYLO1: rdata = {6'h0, lo1};
				cp0_pkg::BADVADDR: rdata = badvaddr;
				cp0_pkg::COUNT:    rdata = count;
				cp0_pkg::ENTRYHI:  rdata = entryhi;
				cp0_pkg::COMPARE:  rdata = compare;
				cp0_pkg::STATUS:   rdata = status;
				cp0_pkg::CAUSE:    rdata = cause;
				cp0_pkg::EPC:      rdata = epc;
				default:           rdata = '0;
			endcase
		end
	end

	assign int_happen = !exl && ie && |(im & ip);

	always_ff @(posedge clk) begin
		if (wr_status)
			im <= wdata[15:8];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			exl <= 1'b0;
			ie <= 1'b0;
		end else begin
			if (info.any)
				exl <= 1'b1;
			else if (eret)
				exl <= 1'b0;
			else if (wr_status)
				exl <= wdata[1];
			if (wr_status)
				ie <= wdata[0];
		end
	end

	// hardware lines land one cycle late, IP7 shares with the timer
	always_ff @(posedge clk) begin
		if (rst) begin
			bd <= 1'b0;
			ip <= '0;
			exccode <= cp0_pkg::INT;
		end else begin
			ip[7:2] <= {int_num[5] | ti, int_num[4:0]};
			if (wr_cause)
				ip[1:0] <= wdata[9:8];
			if (info.any && !exl)
				bd <= is_slot;
			if (info.any)
				exccode <= info.code;
		end
	end

	// nested exception keeps the first return address
	always_ff @(posedge clk) begin
		if (info.any && !exl)
			epc <= is_slot ? pc - 32'd4 : pc;
		else if (wr_epc)
			epc <= wdata;
	end

	always_ff @(posedge clk) begin
		if (info.badv_wen)
			badvaddr <= bad_vaddr;
	end

	always_ff @(posedge clk) begin
		if (rst)
			index_p <= 1'b0;
		else if (tlbp_wen)
			index_p <= probe.miss;
	end

	always_ff @(posedge clk) begin
		if (tlbp_wen)
			index_v <= probe.index[IW-1:0];
		else if (wr_index)
			index_v <= wdata[IW-1:0];
	end

	always_ff @(posedge clk) begin
		if (info.tlb)
			ehi_vpn2 <= bad_vaddr[31:13];
		else if (tlbr_wen)
			ehi_vpn2 <= rd_entry.vpn2;
		else if (wr_entryhi)
			ehi_vpn2 <= wdata[31:13];
		if (tlbr_wen)
			ehi_asid <= rd_entry.asid;
		else if (wr_entryhi)
			ehi_asid <= wdata[7:0];
	end

	always_ff @(posedge clk) begin
		if (tlbr_wen) begin
			lo0 <= {rd_entry.pfn0, rd_entry.c0, rd_entry.d0, rd_entry.v0, rd_entry.g};
			lo1 <= {rd_entry.pfn1, rd_entry.c1, rd_entry.d1, rd_entry.v1, rd_entry.g};
		end else begin
			if (wr_entrylo0)
				lo0 <= wdata[25:0];
			if (wr_entrylo1)
				lo1 <= wdata[25:0];
		end
	end

	assign tlb_index = index_v;

	// global only when both halves say so
	assign wi_entry = '{
		vpn2: ehi_vpn2, asid: ehi_asid, g: lo0[0] & lo1[0],
		pfn0: lo0[25:6], c0: lo0[5:3], d0: lo0[2], v0: lo0[1],
		pfn1: lo1[25:6], c1: lo1[5:3], d1: lo1[2], v1: lo1[1]
	};

	// the op sequencer never commits a probe and a read at once
	a_tlb_wen_excl: assert property (@(posedge clk) disable iff (rst)
		!(tlbp_wen && tlbr_wen));

endmodule

// File: cp0_timer.sv
`timescale 1ns/10ps

module cp0_timer (
	input  logic        clk,
	input  logic        rst,
	input  logic        count_wen,
	input  logic        compare_wen,
	input  logic [31:0] wdata,
	output logic [31:0] count,
	output logic [31:0] compare,
	output logic        ti
);

	// bit 0 halves the rate, Count moves every second clock
	logic [32:0] cnt;

	assign count = cnt[32:1];

	always_ff @(posedge clk) begin
		if (rst)
			cnt <= '0;
		else if (count_wen)
			cnt <= {wdata, 1'b0};
		else
			cnt <= cnt + 33'd1;
	end

	always_ff @(posedge clk) begin
		if (compare_wen)
			compare <= wdata;
	end

	// sticky until software rewrites Compare
	always_ff @(posedge clk) begin
		if (rst)
			ti <= 1'b0;
		else if (compare_wen)
			ti <= 1'b0;
		else if (count == compare)
			ti <= 1'b1;
	end

endmodule

// File: cp0_tlb_top.sv
`timescale 1ns/10ps

module cp0_tlb_top #(
	parameter int TLBNUM = 16
) (
	input  logic              clk,
	input  logic              rst,
	input  logic [7:0]        cp0_addr,
	input  logic              cp0_wen,
	input  logic [31:0]       cp0_wdata,
	output logic [31:0]       cp0_rdata,
	input  cp0_pkg::exc_vec_t exc,
	input  logic [31:0]       pc,
	input  logic              is_slot,
	input  logic [31:0]       bad_vaddr,
	input  logic [5:0]        int_num,
	input  logic              eret,
	output logic [31:0]       epc,
	output logic              int_happen,
	output logic              tlb_refill,
	input  cp0_pkg::tlb_op_e  tlb_op,
	input  logic              tlb_op_valid,
	output logic              tlb_busy,
	output logic              tlb_done
);

	cp0_pkg::exc_info_t        info;
	logic                      count_wen, compare_wen, ti;
	logic [31:0]               count, compare, entryhi;
	logic [$clog2(TLBNUM)-1:0] tlb_index;
	cp0_pkg::tlb_entry_t       wi_entry, rd_entry;
	cp0_pkg::probe_res_t       probe;
	logic                      search_en, read_en, write_en;
	logic                      tlbp_wen, tlbr_wen;

	assign tlb_refill = info.refill;

	cp0_exc_prio cp0_exc_prio_inst (
		.exc  (exc),
		.info (info)
	);

	cp0_timer cp0_timer_inst (
		.clk         (clk),
		.rst         (rst),
		.count_wen   (count_wen),
		.compare_wen (compare_wen),
		.wdata       (cp0_wdata),
		.count       (count),
		.compare     (compare),
		.ti          (ti)
	);

	cp0_regs #(.TLBNUM(TLBNUM)) cp0_regs_inst (
		.clk         (clk),
		.rst         (rst),
		.addr        (cp0_addr),
		.wen         (cp0_wen),
		.wdata       (cp0_wdata),
		.rdata       (cp0_rdata),
		.info        (info),
		.pc          (pc),
		.is_slot     (is_slot),
		.bad_vaddr   (bad_vaddr),
		.int_num     (int_num),
		.eret        (eret),
		.epc         (epc),
		.int_happen  (int_happen),
		.count_wen   (count_wen),
		.compare_wen (compare_wen),
		.count       (count),
		.compare     (compare),
		.ti          (ti),
		.tlbp_wen    (tlbp_wen),
		.tlbr_wen    (tlbr_wen),
		.probe       (probe),
		.rd_entry    (rd_entry),
		.entryhi     (entryhi),
		.tlb_index   (tlb_index),
		.wi_entry    (wi_entry)
	);

	tlb_array #(.TLBNUM(TLBNUM)) tlb_array_inst (
		.clk       (clk),
		.rst       (rst),
		.search_en (search_en),
		.read_en   (read_en),
		.write_en  (write_en),
		.entryhi   (entryhi),
		.index     (tlb_index),
		.wi_entry  (wi_entry),
		.probe     (probe),
		.rd_entry  (rd_entry)
	);

	tlb_op_ctrl tlb_op_ctrl_inst (
		.clk       (clk),
		.rst       (rst),
		.op        (tlb_op),
		.op_valid  (tlb_op_valid),
		.search_en (search_en),
		.read_en   (read_en),
		.write_en  (write_en),
		.tlbp_wen  (tlbp_wen),
		.tlbr_wen  (tlbr_wen),
		.busy      (tlb_busy),
		.done      (tlb_done)
	);

endmodule

// File: src.f
cp0_pkg.sv
cp0_exc_prio.sv
cp0_timer.sv
cp0_regs.sv
tlb_array.sv
tlb_op_ctrl.sv
cp0_tlb_top.sv
tb_cp0_tlb.sv

// File: tb_cp0_tlb.sv
`timescale 1ns/10ps

module tb_cp0_tlb;

	localparam int TLBNUM = 16;
	localparam int MAX_STEPS = 256;

	// flag positions inside exc_vec_t
	localparam int B_INTR = 7;
	localparam int B_SYS = 3;
	localparam int B_BP = 2;
	localparam int B_REFILL_LD = 12;

	typedef enum logic [2:0] {
		K_WR, K_RD, K_EXC, K_ERET, K_TLB, K_WAIT, K_INT, K_ARM
	} step_kind_e;

	typedef struct packed {
		step_kind_e  kind;
		logic [7:0]  addr;
		logic [31:0] data;
		logic [14:0] exc;
		logic [31:0] pc;
		logic        slot;
		logic [31:0] exp;
		logic [31:0] mask;
	} step_t;

	// flags in priority order with refill ahead of invalid
	localparam int RANK [15] = '{7, 6, 14, 13, 1, 3, 2, 0, 5, 4, 12, 11, 10, 9, 8};
	// code per flag by bit position
	localparam logic [4:0] CODE_OF [15] = '{
		cp0_pkg::OV, cp0_pkg::RI, cp0_pkg::BP, cp0_pkg::SYS, cp0_pkg::ADES,
		cp0_pkg::ADEL, cp0_pkg::ADEL, cp0_pkg::INT, cp0_pkg::MOD, cp0_pkg::TLBS,
		cp0_pkg::TLBS, cp0_pkg::TLBL, cp0_pkg::TLBL, cp0_pkg::TLBL, cp0_pkg::TLBL
	};
	localparam logic [14:0] MULTI_VECS [4] = '{15'h00c8, 15'h0500, 15'h0c00, 15'h0023};

	logic              clk;
	logic              rst;
	logic [7:0]        cp0_addr;
	logic              cp0_wen;
	logic [31:0]       cp0_wdata;
	logic [31:0]       cp0_rdata;
	cp0_pkg::exc_vec_t exc;
	logic [31:0]       pc;
	logic              is_slot;
	logic [31:0]       bad_vaddr;
	logic [5:0]        int_num;
	logic              eret;
	logic [31:0]       epc;
	logic              int_happen;
	logic              tlb_refill;
	cp0_pkg::tlb_op_e  tlb_op;
	logic              tlb_op_valid;
	logic              tlb_busy;
	logic              tlb_done;

	step_t       steps [MAX_STEPS];
	string       names [MAX_STEPS];
	int          n_steps = 0;
	logic        table_ready = 1'b0;
	logic [31:0] lfsr_state = 32'hd05c;

	cp0_tlb_top #(.TLBNUM(TLBNUM)) cp0_tlb_top_inst (
		.clk          (clk),
		.rst          (rst),
		.cp0_addr     (cp0_addr),
		.cp0_wen      (cp0_wen),
		.cp0_wdata    (cp0_wdata),
		.cp0_rdata    (cp0_rdata),
		.exc          (exc),
		.pc           (pc),
		.is_slot      (is_slot),
		.bad_vaddr    (bad_vaddr),
		.int_num      (int_num),
		.eret         (eret),
		.epc          (epc),
		.int_happen   (int_happen),
		.tlb_refill   (tlb_refill),
		.tlb_op       (tlb_op),
		.tlb_op_valid (tlb_op_valid),
		.tlb_busy     (tlb_busy),
		.tlb_done     (tlb_done)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic next_bit();
		logic b;
		b = lfsr_state[0];
		lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
		return b;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++)
			r = {r[30:0], next_bit()};
		return r;
	endfunction

	// {refill, code} of the winning flag
	function automatic logic [5:0] prio_model(input logic [14:0] v);
		int win;
		win = 7;
		for (int k = 14; k >= 0; k--)
			if (v[RANK[k]])
				win = RANK[k];
		return {win == 14 || win == 12 || win == 10, CODE_OF[win]};
	endfunction

	function automatic logic [31:0] cause_val(input logic bd, input logic [4:0] code);
		return {bd, 24'h0, code, 2'b00};
	endfunction

	function automatic logic [7:0] reg_addr(input cp0_pkg::cp0_reg_e r);
		return {r, 3'b000};
	endfunction

	task automatic add_step(input string nm, input step_kind_e k, input logic [7:0] a,
			input logic [31:0] d, input logic [14:0] v, input logic [31:0] p,
			input logic sl, input logic [31:0] e, input logic [31:0] m);
		names[n_steps] = nm;
		steps[n_steps] = '{k, a, d, v, p, sl, e, m};
		n_steps++;
	endtask

	task automatic add_wr(input string nm, input cp0_pkg::cp0_reg_e r, input logic [31:0] d);
		add_step(nm, K_WR, reg_addr(r), d, '0, '0, 1'b0, '0, '0);
	endtask

	task automatic add_rd(input string nm, input cp0_pkg::cp0_reg_e r, input logic [31:0] e,
			input logic [31:0] m);
		add_step(nm, K_RD, reg_addr(r), '0, '0, '0, 1'b0, e, m);
	endtask

	task automatic add_exc(input string nm, input logic [14:0] v, input logic [31:0] p,
			input logic sl, input logic [31:0] bva, input logic refill);
		add_step(nm, K_EXC, '0, bva, v, p, sl, {31'h0, refill}, '1);
	endtask

	task automatic add_ctl(input string nm, input step_kind_e k, input logic [31:0] d);
		add_step(nm, k, '0, d, '0, '0, 1'b0, d, '1);
	endtask

	task automatic build_table();
		logic [31:0] d, p, q, bva, ehi, lo0, lo1;
		logic [14:0] v;
		logic [5:0]  m;
		logic [3:0]  idx;
		// keep TI low until the timer section
		add_wr("compare_park", cp0_pkg::COMPARE, 32'hffff_0000);
		add_ctl("ti_settle", K_WAIT, 32'd2);
		add_rd("cause_after_reset", cp0_pkg::CAUSE, 32'h0, '1);
		add_rd("status_after_reset", cp0_pkg::STATUS, 32'h0040_0000, 32'h0040_0003);
		add_rd("index_after_reset", cp0_pkg::INDEX, 32'h0, 32'hffff_fff0);
		for (int i = 0; i < 3; i++) begin
			d = rand_bits(32);
			add_wr("status_wr", cp0_pkg::STATUS, d);
			add_rd("status_rd", cp0_pkg::STATUS, (d & 32'h0000_ff03) | 32'h0040_0000, '1);
			d = rand_bits(32);
			add_wr("cause_wr", cp0_pkg::CAUSE, d);
			add_rd("cause_rd", cp0_pkg::CAUSE, d & 32'h0000_0300, '1);
			d = rand_bits(32);
			add_wr("entryhi_wr", cp0_pkg::ENTRYHI, d);
			add_rd("entryhi_rd", cp0_pkg::ENTRYHI, d & 32'hffff_e0ff, '1);
			d = rand_bits(32);
			add_wr("entrylo0_wr", cp0_pkg::ENTRYLO0, d);
			add_rd("entrylo0_rd", cp0_pkg::ENTRYLO0, d & 32'h03ff_ffff, '1);
			d = rand_bits(32);
			add_wr("entrylo1_wr", cp0_pkg::ENTRYLO1, d);
			add_rd("entrylo1_rd", cp0_pkg::ENTRYLO1, d & 32'h03ff_ffff, '1);
			d = rand_bits(32);
			add_wr("index_wr", cp0_pkg::INDEX, d);
			add_rd("index_rd", cp0_pkg::INDEX, d & 32'h0000_000f, '1);
		end
		add_wr("status_clear", cp0_pkg::STATUS, 32'h0);
		add_wr("cause_clear", cp0_pkg::CAUSE, 32'h0);

		// one flag at a time with odd flags in a delay slot
		for (int i = 0; i < 15; i++) begin
			v = 15'(1) << i;
			m = prio_model(v);
			p = rand_bits(32) & 32'hffff_fffc;
			bva = rand_bits(32);
			add_exc($sformatf("flag%0d_exc", i), v, p, i[0], bva, m[5]);
			add_rd($sformatf("flag%0d_cause", i), cp0_pkg::CAUSE, cause_val(i[0], m[4:0]), '1);
			add_rd($sformatf("flag%0d_epc", i), cp0_pkg::EPC, i[0] ? p - 32'd4 : p, '1);
			add_ctl($sformatf("flag%0d_eret", i), K_ERET, 32'h0);
		end

		for (int i = 0; i < 12; i++) begin
			v = (i < 4) ? MULTI_VECS[i] : 15'(rand_bits(15));
			if (v == '0)
				v = 15'h0001;
			m = prio_model(v);
			p = rand_bits(32) & 32'hffff_fffc;
			add_exc($sformatf("prio%0d_exc", i), v, p, 1'b0, 32'h0, m[5]);
			add_rd($sformatf("prio%0d_cause", i), cp0_pkg::CAUSE, cause_val(1'b0, m[4:0]), '1);
			add_ctl($sformatf("prio%0d_eret", i), K_ERET, 32'h0);
		end

		p = rand_bits(32) & 32'hffff_fffc;
		q = rand_bits(32) & 32'hffff_fffc;
		add_exc("nest_first", 15'(1) << B_SYS, p, 1'b0, 32'h0, 1'b0);
		add_rd("nest_status_exl", cp0_pkg::STATUS, 32'h0040_0002, '1);
		add_exc("nest_second", 15'(1) << B_BP, q, 1'b1, 32'h0, 1'b0);
		add_rd("nest_cause", cp0_pkg::CAUSE, cause_val(1'b0, cp0_pkg::BP), 32'h0000_007c);
		add_rd("nest_epc", cp0_pkg::EPC, p, '1);
		add_ctl("nest_eret", K_ERET, 32'h0);
		add_rd("nest_status_eret", cp0_pkg::STATUS, 32'h0040_0000, '1);

		// leave ExcCode at INT with BD clear for the timer check
		add_exc("int_code_reset", 15'(1) << B_INTR, 32'h0, 1'b0, 32'h0, 1'b0);
		add_ctl("int_code_eret", K_ERET, 32'h0);
		add_wr("int_sw_ip0", cp0_pkg::CAUSE, 32'h0000_0100);
		add_wr("int_enable", cp0_pkg::STATUS, 32'h0000_0101);
		add_ctl("int_on", K_INT, 32'h1);
		add_wr("int_im_clear", cp0_pkg::STATUS, 32'h0000_0001);
		add_ctl("int_im_off", K_INT, 32'h0);
		add_wr("int_exl_set", cp0_pkg::STATUS, 32'h0000_0103);
		add_ctl("int_exl_off", K_INT, 32'h0);
		add_wr("int_status_clear", cp0_pkg::STATUS, 32'h0);
		add_wr("int_cause_clear", cp0_pkg::CAUSE, 32'h0);

		add_ctl("timer_arm", K_ARM, 32'h0);
		add_ctl("timer_run", K_WAIT, 32'd12);
		add_rd("timer_cause_ti", cp0_pkg::CAUSE, 32'h4000_8000, '1);
		add_wr("timer_compare_wr", cp0_pkg::COMPARE, 32'hffff_0000);
		add_ctl("timer_settle", K_WAIT, 32'd2);
		add_rd("timer_cause_clear", cp0_pkg::CAUSE, 32'h0, '1);

		ehi = (rand_bits(32) | 32'h8000_0000) & 32'hffff_e0ff;
		lo0 = rand_bits(32) & 32'h03ff_fffe;
		lo1 = rand_bits(32) & 32'h03ff_fffe;
		idx = 4'(rand_bits(4));
		add_wr("tlb_ehi_load", cp0_pkg::ENTRYHI, ehi);
		add_wr("tlb_lo0_load", cp0_pkg::ENTRYLO0, lo0);
		add_wr("tlb_lo1_load", cp0_pkg::ENTRYLO1, lo1);
		add_wr("tlb_index_load", cp0_pkg::INDEX, {28'h0, idx});
		add_ctl("tlbwi", K_TLB, 32'(cp0_pkg::TLB_WI));
		add_wr("tlb_ehi_zero", cp0_pkg::ENTRYHI, 32'h0);
		add_wr("tlb_lo0_zero", cp0_pkg::ENTRYLO0, 32'h0);
		add_wr("tlb_lo1_zero", cp0_pkg::ENTRYLO1, 32'h0);
		add_ctl("tlbr", K_TLB, 32'(cp0_pkg::TLB_R));
		add_rd("tlbr_ehi", cp0_pkg::ENTRYHI, ehi, '1);
		add_rd("tlbr_lo0", cp0_pkg::ENTRYLO0, lo0, '1);
		add_rd("tlbr_lo1", cp0_pkg::ENTRYLO1, lo1, '1);
		add_wr("tlbp_index_other", cp0_pkg::INDEX, {28'h0, idx ^ 4'h5});
		add_ctl("tlbp_hit", K_TLB, 32'(cp0_pkg::TLB_P));
		add_rd("tlbp_hit_index", cp0_pkg::INDEX, {28'h0, idx}, '1);
		add_wr("tlbp_ehi_other", cp0_pkg::ENTRYHI, ehi ^ 32'h4000_0000);
		add_ctl("tlbp_miss", K_TLB, 32'(cp0_pkg::TLB_P));
		add_rd("tlbp_miss_index", cp0_pkg::INDEX, 32'h8000_0000, 32'h8000_0000);

		bva = rand_bits(32);
		add_exc("refill_exc", 15'(1) << B_REFILL_LD, 32'h0000_1000, 1'b0, bva, 1'b1);
		add_rd("refill_ehi", cp0_pkg::ENTRYHI, bva, 32'hffff_e000);
		add_rd("refill_badvaddr", cp0_pkg::BADVADDR, bva, '1);
		add_ctl("refill_eret", K_ERET, 32'h0);
	endtask

	task automatic check(input string nm, input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			$display("MISMATCH %s expected %08h actual %08h", nm, expected, actual);
			$display("=== FAIL ===");
			$fatal(1);
		end
	endtask

	task automatic drive_idle();
		cp0_addr <= '0;
		cp0_wen <= 1'b0;
		cp0_wdata <= '0;
		exc <= '0;
		pc <= '0;
		is_slot <= 1'b0;
		bad_vaddr <= '0;
		int_num <= '0;
		eret <= 1'b0;
		tlb_op <= cp0_pkg::TLB_NONE;
		tlb_op_valid <= 1'b0;
	endtask

	task automatic run_step(input int i);
		step_t       s;
		string       nm;
		int          waited;
		logic [31:0] cnt_seen;
		s = steps[i];
		nm = names[i];
		@(posedge clk);
		drive_idle();
		case (s.kind)
			K_WR: begin
				cp0_addr <= s.addr;
				cp0_wen <= 1'b1;
				cp0_wdata <= s.data;
			end
			K_RD: cp0_addr <= s.addr;
			K_EXC: begin
				exc <= s.exc;
				pc <= s.pc;
				is_slot <= s.slot;
				bad_vaddr <= s.data;
			end
			K_ERET: eret <= 1'b1;
			K_TLB: begin
				tlb_op <= cp0_pkg::tlb_op_e'(s.data[1:0]);
				tlb_op_valid <= 1'b1;
			end
			K_ARM: cp0_addr <= reg_addr(cp0_pkg::COUNT);
			default: ;
		endcase
		@(negedge clk);
		case (s.kind)
			K_RD: begin
				check(nm, s.exp & s.mask, cp0_rdata & s.mask);
				// the epc output mirrors the EPC register
				if (s.addr == reg_addr(cp0_pkg::EPC))
					check({nm, "_port"}, s.exp & s.mask, epc & s.mask);
			end
			K_EXC: check(nm, s.exp, {31'h0, tlb_refill});
			K_INT: check(nm, s.exp, {31'h0, int_happen});
			K_WAIT: repeat (s.data) @(posedge clk);
			K_ARM: begin
				cnt_seen = cp0_rdata;
				@(posedge clk);
				cp0_addr <= reg_addr(cp0_pkg::COMPARE);
				cp0_wen <= 1'b1;
				cp0_wdata <= cnt_seen + 32'd3;
			end
			K_TLB: begin
				waited = 0;
				while (!tlb_done) begin
					if (waited == 4) begin
						$display("TLB op %s never finished, tlb_done stayed low for 4 cycles", nm);
						$display("=== FAIL ===");
						$fatal(1);
					end
					@(posedge clk);
					tlb_op_valid <= 1'b0;
					@(negedge clk);
					check({nm, "_busy"}, 32'h1, {31'h0, tlb_busy});
					waited++;
				end
			end
			default: ;
		endcase
	endtask

	initial begin
		rst = 1'b1;
		cp0_addr = '0;
		cp0_wen = 1'b0;
		cp0_wdata = '0;
		exc = '0;
		pc = '0;
		is_slot = 1'b0;
		bad_vaddr = '0;
		int_num = '0;
		eret = 1'b0;
		tlb_op = cp0_pkg::TLB_NONE;
		tlb_op_valid = 1'b0;
		build_table();
		table_ready = 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		for (int i = 0; i < n_steps; i++)
			run_step(i);
		@(posedge clk);
		$display("=== PASS ===");
		$finish;
	end

	initial begin
		wait (table_ready);
		repeat (n_steps * 64) @(posedge clk);
		$display("watchdog expired before the step table completed");
		$display("=== FAIL ===");
		$fatal(1);
	end

endmodule

// File: tlb_array.sv
`timescale 1ns/10ps

module tlb_array #(
	parameter int TLBNUM = 16
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      search_en,
	input  logic                      read_en,
	input  logic                      write_en,
	input  logic [31:0]               entryhi,
	input  logic [$clog2(TLBNUM)-1:0] index,
	input  cp0_pkg::tlb_entry_t       wi_entry,
	output cp0_pkg::probe_res_t       probe,
	output cp0_pkg::tlb_entry_t       rd_entry
);

	localparam int IW = $clog2(TLBNUM);

	cp0_pkg::tlb_entry_t ents [TLBNUM];
	logic                hit;
	logic [IW-1:0]       hit_idx;

	// scan downwards so the lowest matching entry wins
	always_comb begin
		hit = 1'b0;
		hit_idx = '0;
		for (int i = TLBNUM - 1; i >= 0; i--) begin
			if (ents[i].vpn2 == entryhi[31:13] &&
			    (ents[i].g || ents[i].asid == entryhi[7:0])) begin
				hit = 1'b1;
				hit_idx = IW'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < TLBNUM; i++) begin
				ents[i].v0 <= 1'b0;
				ents[i].v1 <= 1'b0;
			end
		end else if (write_en) begin
			ents[index] <= wi_entry;
		end
	end

	always_ff @(posedge clk) begin
		if (search_en) begin
			probe.miss <= !hit;
			probe.index <= 31'(hit_idx);
		end
		if (read_en)
			rd_entry <= ents[index];
	end

	a_one_op: assert property (@(posedge clk) disable iff (rst)
		$onehot0({search_en, read_en, write_en}));

endmodule

// File: tlb_op_ctrl.sv
`timescale 1ns/10ps

module tlb_op_ctrl (
	input  logic              clk,
	input  logic              rst,
	input  cp0_pkg::tlb_op_e  op,
	input  logic              op_valid,
	output logic              search_en,
	output logic              read_en,
	output logic              write_en,
	output logic              tlbp_wen,
	output logic              tlbr_wen,
	output logic              busy,
	output logic              done
);

	typedef enum logic [1:0] {
		IDLE,
		LOOKUP,
		COMMIT
	} state_e;

	state_e           state;
	cp0_pkg::tlb_op_e op_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			op_q <= cp0_pkg::TLB_NONE;
		end else begin
			case (state)
				IDLE: begin
					if (op_valid) begin
						state <= LOOKUP;
						op_q <= op;
					end
				end
				LOOKUP:  state <= COMMIT;
				default: state <= IDLE;
			endcase
		end
	end

	// array acts in LOOKUP, registers take its result in COMMIT
	assign search_en = state == LOOKUP && op_q == cp0_pkg::TLB_P;
	assign read_en   = state == LOOKUP && op_q == cp0_pkg::TLB_R;
	assign write_en  = state == LOOKUP && op_q == cp0_pkg::TLB_WI;
	assign tlbp_wen  = state == COMMIT && op_q == cp0_pkg::TLB_P;
	assign tlbr_wen  = state == COMMIT && op_q == cp0_pkg::TLB_R;
	assign done      = state == COMMIT;
	assign busy      = state != IDLE;

	a_no_strobe_busy: assert property (@(posedge clk) disable iff (rst)
		busy |-> !op_valid);

endmodule
